/* project.f */
+incdir+hw
hw/ht_types_pkg.sv
hw/ht_ctrl_pkg.sv
hw/h3_hash.sv
hw/table_bank.sv
hw/forward_unit.sv
hw/ht_controller.sv
hw/hash_table.sv
verif/hash_table_tb.sv

/* Makefile */
SIM  := obj_dir/Vhash_table_tb
SRCS := $(wildcard hw/*.sv hw/*.svh verif/*.sv)

.PHONY: all run clean

all: run

$(SIM): project.f $(SRCS)
	verilator --binary --timing -f project.f --top-module hash_table_tb -o Vhash_table_tb

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

/* verif/hash_table_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ht_defines.svh"

module hash_table_tb;

    import ht_types_pkg::*;
    import ht_ctrl_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_REQS   = 2000;
    localparam int TIMEOUT_NS = 4 * NUM_REQS * CLK_PERIOD;
    localparam int SLOTS      = 2 ** `HT_ADR_WIDTH;
    localparam int POOL_SIZE  = 16;

    logic    clk;
    logic    rst_n_i;
    logic    ready_i;
    req_t    req_i;
    h3_set_t h3_matrix_i;
    resp_t   resp_o;

    entry_t  slots [`HT_NUM_TABLES][SLOTS];  // reference model content
    key_t    key_pool [POOL_SIZE];
    resp_t   exp_q [$];
    resp_t   last_resp;
    logic    s1_busy;                        // a request sits in stage 1
    int      issued;
    int      checked;

    hash_table dut0 (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .ready_i     (ready_i),
        .req_i       (req_i),
        .h3_matrix_i (h3_matrix_i),
        .resp_o      (resp_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: response %0d data 0x%h, expected 0x%h",
                     $time, checked, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_status(input status_t got, input status_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: response %0d status %b, expected %b",
                     $time, checked, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_op(input op_e got, input op_e exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: response %0d op %0d, expected %0d",
                     $time, checked, got, exp);
            stop_with_failure();
        end
    endtask

    // xor of the rows whose key bit is one
    function automatic tbl_adr_t model_hash(input key_t key, input h3_matrix_t m);
        tbl_adr_t h;
        h = '0;
        for (int b = 0; b < `HT_KEY_WIDTH; b++) begin
            if (key[b]) begin
                h = h ^ m[b];
            end
        end
        return h;
    endfunction

    task automatic apply_model(input req_t r, output resp_t exp);
        tbl_adr_t a [`HT_NUM_TABLES];
        int       hit_t;
        int       free_t;
        hit_t  = -1;
        free_t = -1;
        exp    = '0;
        exp.valid = 1'b1;
        exp.op    = r.op;
        for (int t = 0; t < `HT_NUM_TABLES; t++) begin
            a[t] = model_hash(r.key, h3_matrix_i[t]);
            if (hit_t < 0 && slots[t][a[t]].valid && slots[t][a[t]].key == r.key) begin
                hit_t = t;
            end
            if (free_t < 0 && !slots[t][a[t]].valid) begin
                free_t = t;
            end
        end
        case (r.op)
            OP_READ: begin
                if (hit_t >= 0) exp.data = slots[hit_t][a[hit_t]].data;
                else exp.status.no_element_found = 1'b1;
            end
            OP_WRITE: begin
                if (hit_t >= 0) exp.status.key_already_present = 1'b1;
                else if (free_t < 0) exp.status.no_write_space = 1'b1;
                else slots[free_t][a[free_t]] = '{valid: 1'b1, key: r.key, data: r.data};
            end
            OP_DELETE: begin
                if (hit_t >= 0) slots[hit_t][a[hit_t]].valid = 1'b0;
                else exp.status.no_deletion_target = 1'b1;
            end
            default: begin
            end
        endcase
    endtask

    task automatic drive_request();
        req_t       r;
        resp_t      exp;
        logic [1:0] op_bits;
        r       = '0;
        ready_i = ($urandom_range(0, 3) != 0);  // stall on about a quarter of cycles
        r.valid = ($urandom_range(0, 7) != 0);
        op_bits = 2'($urandom_range(1, 3));
        r.op    = op_e'(op_bits);
        r.key   = key_pool[$urandom_range(0, POOL_SIZE - 1)];
        r.data  = data_t'($urandom);
        req_i   = r;
        if (ready_i && r.valid) begin
            apply_model(r, exp);
            exp_q.push_back(exp);
            issued++;
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before all responses came back");
        stop_with_failure();
    end

    initial begin
        resp_t exp;
        logic  exp_valid;
        void'($urandom(32'he507de53));
        clk         = 1'b0;
        rst_n_i     = 1'b0;
        ready_i     = 1'b0;
        req_i       = '0;
        s1_busy     = 1'b0;
        issued      = 0;
        checked     = 0;
        for (int t = 0; t < `HT_NUM_TABLES; t++) begin
            for (int b = 0; b < `HT_KEY_WIDTH; b++) begin
                h3_matrix_i[t][b] = h3_row_t'($urandom);
            end
            for (int s = 0; s < SLOTS; s++) begin
                slots[t][s] = '0;
            end
        end
        for (int k = 0; k < POOL_SIZE; k++) begin
            key_pool[k] = key_t'($urandom);
        end
        repeat (4) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
        if (resp_o.valid !== 1'b0) begin
            $display("resp_o.valid is not low after reset");
            stop_with_failure();
        end
        last_resp = resp_o;
        while (issued < NUM_REQS || exp_q.size() != 0) begin
            @(posedge clk);
            #2;
            if (ready_i) begin
                exp_valid = s1_busy;  // stage 1 request answers at this edge
                s1_busy   = req_i.valid;
                if (resp_o.valid !== exp_valid) begin
                    if (exp_valid) $display("missing response at %0t ns", $time);
                    else $display("response without a request at %0t ns", $time);
                    stop_with_failure();
                end
                if (resp_o.valid) begin
                    exp = exp_q.pop_front();
                    check_op(resp_o.op, exp.op);
                    check_data(resp_o.data, exp.data);
                    check_status(resp_o.status, exp.status);
                    checked++;
                end
            end else if (resp_o !== last_resp) begin
                $display("resp_o changed while ready_i was low at %0t ns", $time);
                stop_with_failure();
            end
            last_resp = resp_o;
            if (issued < NUM_REQS) begin
                drive_request();
            end else begin
                ready_i = 1'b1;  // drain the pipeline
                req_i   = '0;
            end
        end
        $display("%0d requests issued, %0d responses checked", issued, checked);
        @(posedge clk);
        #2;
        if (resp_o.valid !== 1'b0) begin
            $display("response without a request after the last one at %0t ns", $time);
            stop_with_failure();
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* hw/hash_table.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ht_defines.svh"

module hash_table (
    input  wire                        clk,
    input  wire                        rst_n_i,
    input  wire                        ready_i,
    input  wire ht_ctrl_pkg::req_t     req_i,
    input  wire ht_types_pkg::h3_set_t h3_matrix_i,
    output ht_ctrl_pkg::resp_t         resp_o
);

    import ht_types_pkg::*;
    import ht_ctrl_pkg::*;

    adr_vec_t   rd_adr;
    adr_vec_t   s1_adr_q;
    req_t       s1_req_q;
    entry_vec_t bank_entries;
    entry_vec_t fwd_entries;
    tbl_wr_t    tbl_wr;

    generate
        for (genvar t = 0; t < `HT_NUM_TABLES; t++) begin : g_table
            h3_hash hash_0 (
                .key_i    (req_i.key),
                .matrix_i (h3_matrix_i[t]),
                .adr_o    (rd_adr[t])
            );

            table_bank #(
                .TABLE_IDX (tbl_idx_t'(t))
            ) block_ram (
                .clk      (clk),
                .rst_n_i  (rst_n_i),
                .en_i     (ready_i),
                .rd_adr_i (rd_adr[t]),
                .wr_i     (tbl_wr),
                .entry_o  (bank_entries[t])
            );
        end
    endgenerate

    // stage 1, lines up with the bank read-out
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_req_q <= '0;
        end else if (ready_i) begin
            s1_req_q <= req_i;
        end
    end

    always_ff @(posedge clk) begin
        if (ready_i) begin
            s1_adr_q <= rd_adr;
        end
    end

    forward_unit forward_updater (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .en_i      (ready_i),
        .wr_i      (tbl_wr),
        .adr_i     (s1_adr_q),
        .entries_i (bank_entries),
        .entries_o (fwd_entries)
    );

    ht_controller controller (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .en_i      (ready_i),
        .req_i     (s1_req_q),
        .adr_i     (s1_adr_q),
        .entries_i (fwd_entries),
        .wr_o      (tbl_wr),
        .resp_o    (resp_o)
    );

endmodule

`default_nettype wire

/* hw/ht_controller.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ht_defines.svh"

module ht_controller (
    input  wire                           clk,
    input  wire                           rst_n_i,
    input  wire                           en_i,
    input  wire ht_ctrl_pkg::req_t        req_i,
    input  wire ht_types_pkg::adr_vec_t   adr_i,
    input  wire ht_types_pkg::entry_vec_t entries_i,
    output ht_ctrl_pkg::tbl_wr_t          wr_o,
    output ht_ctrl_pkg::resp_t            resp_o
);

    import ht_types_pkg::*;
    import ht_ctrl_pkg::*;

    logic     hit;
    tbl_idx_t hit_idx;
    logic     free;
    tbl_idx_t free_idx;
    entry_t   wr_entry;
    status_t  status_d;
    data_t    rd_data_d;

    // walk downwards so the lowest table wins
    always_comb begin
        hit      = 1'b0;
        hit_idx  = '0;
        free     = 1'b0;
        free_idx = '0;
        for (int t = `HT_NUM_TABLES - 1; t >= 0; t--) begin
            if (entries_i[t].valid && entries_i[t].key == req_i.key) begin
                hit     = 1'b1;
                hit_idx = tbl_idx_t'(t);
            end
            if (!entries_i[t].valid) begin
                free     = 1'b1;
                free_idx = tbl_idx_t'(t);
            end
        end
    end

    // the bank takes the write on the same enabled edge as the response
    always_comb begin
        status_d  = '0;
        rd_data_d = '0;
        wr_entry  = entries_i[hit_idx];
        wr_o.en   = 1'b0;
        wr_o.idx  = hit_idx;
        case (req_i.op)
            OP_READ: begin
                if (hit) begin
                    rd_data_d = entries_i[hit_idx].data;
                end else begin
                    status_d.no_element_found = 1'b1;
                end
            end
            OP_WRITE: begin
                wr_entry = '{valid: 1'b1, key: req_i.key, data: req_i.data};
                wr_o.idx = free_idx;
                if (hit) begin
                    status_d.key_already_present = 1'b1;
                end else if (!free) begin
                    status_d.no_write_space = 1'b1;
                end else begin
                    wr_o.en = req_i.valid;
                end
            end
            OP_DELETE: begin
                wr_entry.valid = 1'b0;  // keep key and data, only free the slot
                if (hit) begin
                    wr_o.en = req_i.valid;
                end else begin
                    status_d.no_deletion_target = 1'b1;
                end
            end
            default: begin
            end
        endcase
        wr_o.adr   = adr_i[wr_o.idx];
        wr_o.entry = wr_entry;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            resp_o <= '0;
        end else if (en_i) begin
            resp_o.valid  <= req_i.valid;
            resp_o.op     <= req_i.op;
            resp_o.data   <= rd_data_d;
            resp_o.status <= req_i.valid ? status_d : '0;
        end
    end

endmodule

`default_nettype wire

/* hw/forward_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ht_defines.svh"

module forward_unit (
    input  wire                           clk,
    input  wire                           rst_n_i,
    input  wire                           en_i,
    input  wire ht_ctrl_pkg::tbl_wr_t     wr_i,
    input  wire ht_types_pkg::adr_vec_t   adr_i,
    input  wire ht_types_pkg::entry_vec_t entries_i,
    output ht_types_pkg::entry_vec_t      entries_o
);

    import ht_types_pkg::*;

    logic     fwd_en_q;
    tbl_idx_t fwd_idx_q;
    tbl_adr_t fwd_adr_q;
    entry_t   fwd_entry_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fwd_en_q <= 1'b0;
        end else if (en_i) begin
            fwd_en_q <= wr_i.en;
        end
    end

    // write of the last enabled edge, missed by the bank read-out
    always_ff @(posedge clk) begin
        if (en_i) begin
            fwd_idx_q   <= tbl_idx_t'(wr_i.idx);
            fwd_adr_q   <= tbl_adr_t'(wr_i.adr);
            fwd_entry_q <= entry_t'(wr_i.entry);
        end
    end

    always_comb begin
        for (int t = 0; t < `HT_NUM_TABLES; t++) begin
            if (fwd_en_q && fwd_idx_q == tbl_idx_t'(t) && adr_i[t] == fwd_adr_q) begin
                entries_o[t] = fwd_entry_q;
            end else begin
                entries_o[t] = entries_i[t];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/table_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ht_defines.svh"

module table_bank #(
    parameter ht_types_pkg::tbl_idx_t TABLE_IDX = '0
) (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire                         en_i,
    input  wire ht_types_pkg::tbl_adr_t rd_adr_i,
    input  wire ht_ctrl_pkg::tbl_wr_t   wr_i,
    output ht_types_pkg::entry_t        entry_o
);

    import ht_types_pkg::*;

    localparam int SLOTS = 2 ** `HT_ADR_WIDTH;

    key_t                key_mem  [SLOTS];
    data_t               data_mem [SLOTS];
    logic [SLOTS-1:0]    valid_q;
    key_t                rd_key_q;
    data_t               rd_data_q;
    logic                rd_valid_q;
    entry_t              wr_entry;
    logic                wr_hit;

    assign wr_entry = entry_t'(wr_i.entry);
    assign wr_hit   = wr_i.en && (tbl_idx_t'(wr_i.idx) == TABLE_IDX);

    // read-first, the old slot content comes out on a colliding write
    always_ff @(posedge clk) begin
        if (en_i) begin
            if (wr_hit) begin
                key_mem[wr_i.adr]  <= wr_entry.key;
                data_mem[wr_i.adr] <= wr_entry.data;
            end
            rd_key_q  <= key_mem[rd_adr_i];
            rd_data_q <= data_mem[rd_adr_i];
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q    <= '0;
            rd_valid_q <= 1'b0;
        end else if (en_i) begin
            if (wr_hit) begin
                valid_q[wr_i.adr] <= wr_entry.valid;
            end
            rd_valid_q <= valid_q[rd_adr_i];
        end
    end

    assign entry_o = '{valid: rd_valid_q, key: rd_key_q, data: rd_data_q};

endmodule

`default_nettype wire

/* hw/h3_hash.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ht_defines.svh"

module h3_hash (
    input  wire ht_types_pkg::key_t       key_i,
    input  wire ht_types_pkg::h3_matrix_t matrix_i,
    output ht_types_pkg::tbl_adr_t        adr_o
);

    import ht_types_pkg::*;

    // xor of the rows picked by the set key bits
    always_comb begin
        adr_o = '0;
        for (int b = 0; b < `HT_KEY_WIDTH; b++) begin
            if (key_i[b]) begin
                adr_o = adr_o ^ h3_row_t'(matrix_i[b]);
            end
        end
    end

endmodule

`default_nettype wire

/* hw/ht_ctrl_pkg.sv */
`default_nettype none

`include "ht_defines.svh"

package ht_ctrl_pkg;

    typedef enum logic [`HT_OP_WIDTH-1:0] {
        OP_NOP    = 2'd0,
        OP_READ   = 2'd1,
        OP_WRITE  = 2'd2,
        OP_DELETE = 2'd3
    } op_e;

    typedef struct packed {
        logic                      valid;
        op_e                       op;
        logic [`HT_KEY_WIDTH-1:0]  key;
        logic [`HT_DATA_WIDTH-1:0] data;
    } req_t;

    typedef struct packed {
        logic no_element_found;
        logic key_already_present;
        logic no_write_space;
        logic no_deletion_target;
    } status_t;

    typedef struct packed {
        logic                      valid;
        op_e                       op;
        logic [`HT_DATA_WIDTH-1:0] data;
        status_t                   status;
    } resp_t;

    // one committed write into one table slot
    typedef struct packed {
        logic                       en;
        logic [`HT_IDX_WIDTH-1:0]   idx;
        logic [`HT_ADR_WIDTH-1:0]   adr;
        logic [`HT_ENTRY_WIDTH-1:0] entry;   // same layout as entry_t
    } tbl_wr_t;

endpackage

`default_nettype wire

/* hw/ht_types_pkg.sv */
`default_nettype none

`include "ht_defines.svh"

package ht_types_pkg;

    typedef logic [`HT_KEY_WIDTH-1:0]  key_t;
    typedef logic [`HT_DATA_WIDTH-1:0] data_t;
    typedef logic [`HT_ADR_WIDTH-1:0]  tbl_adr_t;
    typedef logic [`HT_IDX_WIDTH-1:0]  tbl_idx_t;

    // content of one slot
    typedef struct packed {
        logic  valid;
        key_t  key;
        data_t data;
    } entry_t;

    typedef logic [`HT_ADR_WIDTH-1:0] h3_row_t;              // one row per key bit
    typedef h3_row_t [`HT_KEY_WIDTH-1:0] h3_matrix_t;
    typedef h3_matrix_t [`HT_NUM_TABLES-1:0] h3_set_t;

    typedef entry_t [`HT_NUM_TABLES-1:0] entry_vec_t;        // read-out of every table
    typedef tbl_adr_t [`HT_NUM_TABLES-1:0] adr_vec_t;

endpackage

`default_nettype wire

/* hw/ht_defines.svh */
`ifndef HT_DEFINES_SVH
`define HT_DEFINES_SVH

// widths of the stored fields
`define HT_KEY_WIDTH    8
`define HT_DATA_WIDTH   16

// every table has 2**HT_ADR_WIDTH slots
`define HT_ADR_WIDTH    3
`define HT_NUM_TABLES   4

`define HT_IDX_WIDTH    ((`HT_NUM_TABLES > 1) ? $clog2(`HT_NUM_TABLES) : 1)
`define HT_ENTRY_WIDTH  (1 + `HT_KEY_WIDTH + `HT_DATA_WIDTH)  // valid + key + data

// 0 is the idle op
`define HT_OP_WIDTH     2

`endif
